// ==== all.f ====
+incdir+verification
source/cache_bus_pkg.sv
source/cache_geometry_pkg.sv
source/cache_line_store.sv
source/valid_bit_store.sv
source/way_hit_match.sv
source/line_update.sv
source/cache_top.sv
verification/cache_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# builds the cache testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

if ! command -v verilator > /dev/null; then
	echo "verilator not found in PATH"
	exit 1
fi

if ! verilator --binary --timing --assert --timescale 1ns/10ps \
	-f all.f --top-module cache_tb -Mdir obj_dir; then
	echo "build failed"
	exit 1
fi

sim_output=$(./obj_dir/Vcache_tb 2>&1)
sim_status=$?
printf '%s\n' "$sim_output"

if [ "$sim_status" -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if grep -qx 'All tests passed!' <<< "$sim_output"; then
	echo "PASS"
	exit 0
else
	echo "FAIL"
	exit 1
fi

// ==== verification/cache_tb_table.svh ====
// ==============================
// request kinds
// ==============================

localparam logic [1:0] op_read = 2'd0;
localparam logic [1:0] op_write = 2'd1;
localparam logic [1:0] op_load = 2'd2;
localparam logic [1:0] op_inv = 2'd3;

// columns of one row are kind, address, data, select mask, expected hit, expected read data
typedef struct packed {
	logic [1:0] op;
	logic [addr_w-1:0] addr;
	logic [data_w-1:0] data;
	logic [sel_w-1:0] sel;
	logic exp_hit;
	logic [data_w-1:0] exp_data;
} row_t;

// ==============================
// line contents
// ==============================

// byte lane b of a line sits in bits 8b+7 down to 8b
localparam logic [data_w-1:0] no_data = '0;
localparam logic [data_w-1:0] line_a = 128'ha0a1a2a3_a4a5a6a7_a8a9aaab_acadaeaf;
localparam logic [data_w-1:0] line_1 = 128'h10111213_14151617_18191a1b_1c1d1e1f;
localparam logic [data_w-1:0] line_2 = 128'h20212223_24252627_28292a2b_2c2d2e2f;
localparam logic [data_w-1:0] line_3 = 128'h30313233_34353637_38393a3b_3c3d3e3f;
localparam logic [data_w-1:0] line_4 = 128'h40414243_44454647_48494a4b_4c4d4e4f;
localparam logic [data_w-1:0] line_5 = 128'h50515253_54555657_58595a5b_5c5d5e5f;
localparam logic [data_w-1:0] wr_part = 128'hc0c1c2c3_c4c5c6c7_c8c9cacb_cccdcecf;
localparam logic [data_w-1:0] wr_miss = 128'hf0f1f2f3_f4f5f6f7_f8f9fafb_fcfdfeff;

// line 3 after lanes 0 to 3 and 8 to 11 took the write data
localparam logic [data_w-1:0] line_3_merged = 128'h30313233_c4c5c6c7_38393a3b_cccdcecf;

localparam int num_rows = 30;

// set 9 holds tag 0x12 only, set 5 receives tags 1 to 5 in that order
localparam row_t rows [num_rows] = '{
	// nothing is valid right after reset
	'{op_read, 32'h0000_0450, no_data, 16'h0000, 1'b0, no_data},
	'{op_read, 32'h0000_4890, no_data, 16'h0000, 1'b0, no_data},
	'{op_read, 32'h1234_5670, no_data, 16'h0000, 1'b0, no_data},
	// one load, then the same tag hits and another tag of the set misses
	'{op_load, 32'h0000_4890, line_a, 16'h0000, 1'b0, no_data},
	'{op_read, 32'h0000_4890, no_data, 16'h0000, 1'b1, line_a},
	'{op_read, 32'h0000_8890, no_data, 16'h0000, 1'b0, no_data},
	// five loads into set 5 push tag 1 out of way 3
	'{op_load, 32'h0000_0450, line_1, 16'h0000, 1'b0, no_data},
	'{op_load, 32'h0000_0850, line_2, 16'h0000, 1'b0, no_data},
	'{op_load, 32'h0000_0c50, line_3, 16'h0000, 1'b0, no_data},
	'{op_load, 32'h0000_1050, line_4, 16'h0000, 1'b0, no_data},
	'{op_load, 32'h0000_1450, line_5, 16'h0000, 1'b0, no_data},
	'{op_read, 32'h0000_0450, no_data, 16'h0000, 1'b0, no_data},
	'{op_read, 32'h0000_0850, no_data, 16'h0000, 1'b1, line_2},
	'{op_read, 32'h0000_0c50, no_data, 16'h0000, 1'b1, line_3},
	'{op_read, 32'h0000_1050, no_data, 16'h0000, 1'b1, line_4},
	'{op_read, 32'h0000_1450, no_data, 16'h0000, 1'b1, line_5},
	// partial write into tag 3, the offset bits of the address play no part
	'{op_write, 32'h0000_0c58, wr_part, 16'h0f0f, 1'b0, no_data},
	'{op_read, 32'h0000_0c50, no_data, 16'h0000, 1'b1, line_3_merged},
	// write to the evicted tag misses and leaves the set alone
	'{op_write, 32'h0000_0450, wr_miss, 16'hffff, 1'b0, no_data},
	'{op_read, 32'h0000_0850, no_data, 16'h0000, 1'b1, line_2},
	'{op_read, 32'h0000_0c50, no_data, 16'h0000, 1'b1, line_3_merged},
	'{op_read, 32'h0000_1050, no_data, 16'h0000, 1'b1, line_4},
	'{op_read, 32'h0000_1450, no_data, 16'h0000, 1'b1, line_5},
	'{op_read, 32'h0000_0450, no_data, 16'h0000, 1'b0, no_data},
	// invalidate tag 4 only
	'{op_inv, 32'h0000_1050, no_data, 16'h0000, 1'b0, no_data},
	'{op_read, 32'h0000_1050, no_data, 16'h0000, 1'b0, no_data},
	'{op_read, 32'h0000_0850, no_data, 16'h0000, 1'b1, line_2},
	'{op_read, 32'h0000_0c50, no_data, 16'h0000, 1'b1, line_3_merged},
	'{op_read, 32'h0000_1450, no_data, 16'h0000, 1'b1, line_5},
	// the other set never saw any of this
	'{op_read, 32'h0000_4890, no_data, 16'h0000, 1'b1, line_a}
};

// ==== verification/cache_tb.sv ====
`timescale 1ns/10ps

module cache_tb;
	import cache_bus_pkg::*;
	import cache_geometry_pkg::*;

	`include "cache_tb_table.svh"

	// a read hit answers two cycles after the driving edge, a write ack one cycle after
	localparam int read_limit = 4;
	localparam int ack_limit = 4;

	// idle cycles after a write-side request, so the stores are rewritten before the next one
	localparam int gap_cycles = 3;

	logic wclk;
	logic rst;
	logic rd_stb;
	logic [addr_w-1:0] rd_adr;
	logic rd_ack;
	logic [data_w-1:0] rd_dat;
	logic wr_stb;
	logic [addr_w-1:0] wr_adr;
	logic [sel_w-1:0] wr_sel;
	logic [data_w-1:0] wr_dat;
	logic inv;
	logic wr_ack;
	logic ld_stb;
	logic [addr_w-1:0] ld_adr;
	logic [data_w-1:0] ld_dat;

	cache_top dut0 (
		.wclk(wclk),
		.rst(rst),
		.rd_stb(rd_stb),
		.rd_adr(rd_adr),
		.rd_ack(rd_ack),
		.rd_dat(rd_dat),
		.wr_stb(wr_stb),
		.wr_adr(wr_adr),
		.wr_sel(wr_sel),
		.wr_dat(wr_dat),
		.inv(inv),
		.wr_ack(wr_ack),
		.ld_stb(ld_stb),
		.ld_adr(ld_adr),
		.ld_dat(ld_dat)
	);

	// ==============================
	// clock
	// ==============================

	initial begin
		wclk = 1'b0;
		forever begin
			#5 wclk = ~wclk;
		end
	end

	// ==============================
	// checking
	// ==============================

	task automatic check_value(
		input string name,
		input logic [data_w-1:0] actual,
		input logic [data_w-1:0] expected
	);
		if (actual !== expected) begin
			$display("FAIL time=%0t %s: got %h, expected %h", $time, name, actual, expected);
			$display("Test failures found");
			$fatal(1, "stopped at the first mismatch");
		end
	endtask

	task automatic report_timeout(input string what);
		$display("timeout: %s", what);
		$display("Test failures found");
		$fatal(1, "stopped after a timeout");
	endtask

	// ==============================
	// request drivers
	// ==============================

	// outputs are sampled on the falling edge, halfway between two driving edges
	task automatic apply_read(input row_t r);
		int n;
		int ack_cycle;
		logic [data_w-1:0] got;
		ack_cycle = 0;
		got = '0;
		@(posedge wclk);
		rd_stb <= 1'b1;
		rd_adr <= r.addr;
		for (n = 1; n <= read_limit; n++) begin
			@(posedge wclk);
			if (n == 1) begin
				rd_stb <= 1'b0;
			end
			@(negedge wclk);
			// the data output is taken in the cycle where a hit would answer
			if (n == 2) begin
				got = rd_dat;
			end
			if (rd_ack) begin
				ack_cycle = n;
				break;
			end
		end
		// a miss simply runs the loop out, since it never acknowledges
		check_value("rd_ack", data_w'(ack_cycle != 0), data_w'(r.exp_hit))
		;
		if (r.exp_hit) begin
			check_value("rd_ack delay", data_w'(ack_cycle), data_w'(2));
		end
		// on a miss the data output stays at zero
		check_value("rd_dat", got, r.exp_data);
	endtask

	// loads, writes and invalidates all go through the write-side pipeline
	task automatic apply_request(input row_t r);
		int n;
		int ack_cycle;
		ack_cycle = 0;
		@(posedge wclk);
		case (r.op)
			op_load: begin
				ld_stb <= 1'b1;
				ld_adr <= r.addr;
				ld_dat <= r.data;
			end
			op_write: begin
				wr_stb <= 1'b1;
				wr_adr <= r.addr;
				wr_sel <= r.sel;
				wr_dat <= r.data;
			end
			default: begin
				inv <= 1'b1;
				wr_adr <= r.addr;
			end
		endcase
		@(posedge wclk);
		ld_stb <= 1'b0;
		wr_stb <= 1'b0;
		inv <= 1'b0;
		if (r.op == op_write) begin
			for (n = 1; n <= ack_limit; n++) begin
				@(negedge wclk);
				if (wr_ack) begin
					ack_cycle = n;
					break;
				end
				@(posedge wclk);
			end
			if (ack_cycle == 0) begin
				report_timeout($sformatf("no wr_ack within %0d cycles of the write to %h",
					ack_limit, r.addr));
			end else begin
				check_value("wr_ack delay", data_w'(ack_cycle), data_w'(1));
			end
		end else begin
			// only a write is ever acknowledged
			@(negedge wclk);
			check_value("wr_ack", data_w'(wr_ack), '0);
		end
		repeat (gap_cycles) @(posedge wclk);
	endtask

	// ==============================
	// main sequence
	// ==============================

	initial begin
		int i;
		rst <= 1'b1;
		rd_stb <= 1'b0;
		rd_adr <= '0;
		wr_stb <= 1'b0;
		wr_adr <= '0;
		wr_sel <= '0;
		wr_dat <= '0;
		inv <= 1'b0;
		ld_stb <= 1'b0;
		ld_adr <= '0;
		ld_dat <= '0;
		repeat (4) @(posedge wclk);
		rst <= 1'b0;
		for (i = 0; i < num_rows; i++) begin
			if (rows[i].op == op_read) begin
				apply_read(rows[i]);
			end else begin
				apply_request(rows[i]);
			end
		end
		@(posedge wclk);
		$display("All tests passed!");
		$finish;
	end

endmodule

// ==== source/cache_top.sv ====
`timescale 1ns/10ps

module cache_top (
	input  logic wclk,
	input  logic rst,
	input  logic rd_stb,
	input  cache_geometry_pkg::cache_addr_t rd_adr,
	output logic rd_ack,
	output logic [cache_bus_pkg::data_w-1:0] rd_dat,
	input  logic wr_stb,
	input  cache_geometry_pkg::cache_addr_t wr_adr,
	input  logic [cache_bus_pkg::sel_w-1:0] wr_sel,
	input  logic [cache_bus_pkg::data_w-1:0] wr_dat,
	input  logic inv,
	output logic wr_ack,
	input  logic ld_stb,
	input  cache_geometry_pkg::cache_addr_t ld_adr,
	input  logic [cache_bus_pkg::data_w-1:0] ld_dat
);
	import cache_geometry_pkg::*;

	logic [ways*entry_w-1:0] set_a;
	logic [ways*entry_w-1:0] set_b;
	logic [ways-1:0] valid_a;
	logic [ways-1:0] valid_b;

	// write-side lookup and its result
	logic [index_w-1:0] lookup_index;
	cache_addr_t lookup_adr;
	logic lookup_stb;
	logic [ways-1:0] wr_hit;

	// store writes coming back from the updater
	logic store_en;
	logic [index_w-1:0] store_index;
	logic [ways*entry_w-1:0] store_set;
	logic upd_en;
	logic [index_w-1:0] upd_index;
	logic [ways-1:0] upd_valid;

	// ==============================
	// storage
	// ==============================

	cache_line_store u_line_store (
		.wclk(wclk),
		.rd_index_a(rd_adr.fld.index),
		.rd_index_b(lookup_index),
		.set_a(set_a),
		.set_b(set_b),
		.wr_en(store_en),
		.wr_index(store_index),
		.wr_set(store_set)
	);

	valid_bit_store u_valid_store (
		.wclk(wclk),
		.rst(rst),
		.rd_index_a(rd_adr.fld.index),
		.rd_index_b(lookup_index),
		.valid_a(valid_a),
		.valid_b(valid_b),
		.upd_en(upd_en),
		.upd_index(upd_index),
		.upd_valid(upd_valid)
	);

	// ==============================
	// hit detection
	// ==============================

	// the read channel answers straight from its matcher
	way_hit_match rd_match (
		.wclk(wclk),
		.rst(rst),
		.req_stb(rd_stb),
		.req_adr(rd_adr),
		.set(set_a),
		.valid(valid_a),
		.hit(),
		.hit_stb(rd_ack),
		.hit_data(rd_dat)
	);

	// on the write side only the hit vector is needed, the updater has the set
	way_hit_match wr_match (
		.wclk(wclk),
		.rst(rst),
		.req_stb(lookup_stb),
		.req_adr(lookup_adr),
		.set(set_b),
		.valid(valid_b),
		.hit(wr_hit),
		.hit_stb(),
		.hit_data()
	);

	// ==============================
	// update path
	// ==============================

	line_update u_line_update (
		.wclk(wclk),
		.rst(rst),
		.wr_stb(wr_stb),
		.inv(inv),
		.wr_adr(wr_adr),
		.wr_sel(wr_sel),
		.wr_dat(wr_dat),
		.ld_stb(ld_stb),
		.ld_adr(ld_adr),
		.ld_dat(ld_dat),
		.lookup_index(lookup_index),
		.lookup_adr(lookup_adr),
		.lookup_stb(lookup_stb),
		.set_b(set_b),
		.valid_b(valid_b),
		.hit(wr_hit),
		.store_en(store_en),
		.store_index(store_index),
		.store_set(store_set),
		.upd_en(upd_en),
		.upd_index(upd_index),
		.upd_valid(upd_valid),
		.wr_ack(wr_ack)
	);

endmodule

// ==== source/line_update.sv ====
`timescale 1ns/10ps

module line_update (
	input  logic wclk,
	input  logic rst,
	input  logic wr_stb,
	input  logic inv,
	input  cache_geometry_pkg::cache_addr_t wr_adr,
	input  logic [cache_bus_pkg::sel_w-1:0] wr_sel,
	input  logic [cache_bus_pkg::data_w-1:0] wr_dat,
	input  logic ld_stb,
	input  cache_geometry_pkg::cache_addr_t ld_adr,
	input  logic [cache_bus_pkg::data_w-1:0] ld_dat,
	output logic [cache_geometry_pkg::index_w-1:0] lookup_index,
	output cache_geometry_pkg::cache_addr_t lookup_adr,
	output logic lookup_stb,
	input  logic [cache_geometry_pkg::ways*cache_geometry_pkg::entry_w-1:0] set_b,
	input  logic [cache_geometry_pkg::ways-1:0] valid_b,
	input  logic [cache_geometry_pkg::ways-1:0] hit,
	output logic store_en,
	output logic [cache_geometry_pkg::index_w-1:0] store_index,
	output logic [cache_geometry_pkg::ways*cache_geometry_pkg::entry_w-1:0] store_set,
	output logic upd_en,
	output logic [cache_geometry_pkg::index_w-1:0] upd_index,
	output logic [cache_geometry_pkg::ways-1:0] upd_valid,
	output logic wr_ack
);
	import cache_bus_pkg::*;
	import cache_geometry_pkg::*;

	// stage one, the request while the stores are read
	logic s1_ld;
	logic s1_wr;
	logic s1_inv;
	cache_addr_t s1_adr;
	logic [sel_w-1:0] s1_sel;
	logic [data_w-1:0] s1_dat;

	// stage two, the request together with the set that was read for it
	logic s2_ld;
	logic s2_wr;
	logic s2_inv;
	cache_addr_t s2_adr;
	logic [sel_w-1:0] s2_sel;
	logic [data_w-1:0] s2_dat;
	logic [ways*entry_w-1:0] s2_set;
	logic [ways-1:0] s2_valid;

	logic [way_w-1:0] hit_way;
	logic any_hit;
	logic busy;

	// ==============================
	// lookup
	// ==============================

	// a load and a write never come together, so the load address simply wins
	always_comb begin
		lookup_adr.word = ld_stb ? ld_adr.word : wr_adr.word;
	end

	assign lookup_index = lookup_adr.fld.index;
	assign lookup_stb = ld_stb | wr_stb | inv;

	// ==============================
	// pipeline registers
	// ==============================

	always_ff @(posedge wclk) begin
		if (rst) begin
			s1_ld <= 1'b0;
			s1_wr <= 1'b0;
			s1_inv <= 1'b0;
			s2_ld <= 1'b0;
			s2_wr <= 1'b0;
			s2_inv <= 1'b0;
		end else begin
			s1_ld <= ld_stb;
			s1_wr <= wr_stb;
			s1_inv <= inv;
			s2_ld <= s1_ld;
			s2_wr <= s1_wr;
			s2_inv <= s1_inv;
		end
	end

	// the data path carries the load line or the write data, whichever is active
	always_ff @(posedge wclk) begin
		s1_adr <= lookup_adr;
		s1_sel <= wr_sel;
		s1_dat <= ld_stb ? ld_dat : wr_dat;
		s2_adr <= s1_adr;
		s2_sel <= s1_sel;
		s2_dat <= s1_dat;
		s2_set <= set_b;
		s2_valid <= valid_b;
	end

	// ==============================
	// set rebuild
	// ==============================

	// the hit vector is one-hot, so the last set bit names the way
	always_comb begin
		hit_way = '0;
		for (int w = 0; w < ways; w++) begin
			if (hit[w]) begin
				hit_way = way_w'(w);
			end
		end
	end

	assign any_hit = |hit;

	// a load pushes the new line in at way 0 and way 3 falls off the end
	// a write only replaces the selected byte lanes of the way that hit
	always_comb begin
		store_set = s2_set;
		if (s2_ld) begin
			store_set[0 +: entry_w] = {s2_adr.fld.tag, s2_dat};
			for (int w = 1; w < ways; w++) begin
				store_set[w*entry_w +: entry_w] = s2_set[(w-1)*entry_w +: entry_w];
			end
		end else if (s2_wr) begin
			for (int b = 0; b < sel_w; b++) begin
				if (s2_sel[b]) begin
					store_set[hit_way*entry_w + b*byte_w +: byte_w] = s2_dat[b*byte_w +: byte_w];
				end
			end
		end
	end

	// the valid flags shift together with the lines on a load
	always_comb begin
		upd_valid = s2_valid;
		if (s2_ld) begin
			upd_valid = {s2_valid[ways-2:0], 1'b1};
		end else if (s2_inv) begin
			upd_valid[hit_way] = 1'b0;
		end
	end

	// a write that misses leaves both stores alone
	assign store_en = s2_ld | (s2_wr & any_hit);
	assign store_index = s2_adr.fld.index;
	assign upd_en = s2_ld | (s2_inv & any_hit);
	assign upd_index = s2_adr.fld.index;

	// ==============================
	// write acknowledge
	// ==============================

	// every write is acknowledged one cycle on, hit or miss
	always_ff @(posedge wclk) begin
		if (rst) begin
			wr_ack <= 1'b0;
		end else begin
			wr_ack <= wr_stb;
		end
	end

	assign busy = s1_ld | s1_wr | s1_inv | s2_ld | s2_wr | s2_inv;

	a_one_request: assert property (
		@(posedge wclk) disable iff (rst) $onehot0({wr_stb, inv, ld_stb})
	) else $error("more than one write-side strobe at once");

	// a second request inside the pipeline would read a set before it is rewritten
	a_not_busy: assert property (
		@(posedge wclk) disable iff (rst) busy |-> !lookup_stb
	) else $error("write-side request while the update pipeline is busy");

endmodule

// ==== source/way_hit_match.sv ====
`timescale 1ns/10ps

module way_hit_match (
	input  logic wclk,
	input  logic rst,
	input  logic req_stb,
	input  cache_geometry_pkg::cache_addr_t req_adr,
	input  logic [cache_geometry_pkg::ways*cache_geometry_pkg::entry_w-1:0] set,
	input  logic [cache_geometry_pkg::ways-1:0] valid,
	output logic [cache_geometry_pkg::ways-1:0] hit,
	output logic hit_stb,
	output logic [cache_bus_pkg::data_w-1:0] hit_data
);
	import cache_bus_pkg::*;
	import cache_geometry_pkg::*;

	// request held for the cycle in which the stores return its set
	logic stb_q;
	cache_addr_t adr_q;

	// compare result before the output register
	logic [ways-1:0] hit_next;
	logic [data_w-1:0] data_next;

	// ==============================
	// request register
	// ==============================

	// sampled on the same edge as the store read so both line up one cycle later
	always_ff @(posedge wclk) begin
		if (rst) begin
			stb_q <= 1'b0;
		end else begin
			stb_q <= req_stb;
		end
	end

	always_ff @(posedge wclk) begin
		adr_q <= req_adr;
	end

	// ==============================
	// tag compare
	// ==============================

	// a way hits when its flag is set and its stored tag equals the request tag
	// the data of every way that did not hit is masked to zero
	always_comb begin
		hit_next = '0;
		data_next = '0;
		for (int w = 0; w < ways; w++) begin
			if (stb_q && valid[w] && (set[w*entry_w + data_w +: tag_w] == adr_q.fld.tag)) begin
				hit_next[w] = 1'b1;
			end
			if (hit_next[w]) begin
				data_next = data_next | set[w*entry_w +: data_w];
			end
		end
	end

	// ==============================
	// result register
	// ==============================

	always_ff @(posedge wclk) begin
		if (rst) begin
			hit <= '0;
			hit_stb <= 1'b0;
		end else begin
			hit <= hit_next;
			hit_stb <= |hit_next;
		end
	end

	// zero whenever nothing hit, since the masked data was zero
	always_ff @(posedge wclk) begin
		hit_data <= data_next;
	end

	// the load path never stores a tag twice in one set, so at most one way hits
	a_single_hit: assert property (
		@(posedge wclk) disable iff (rst) $onehot0(hit)
	) else $error("more than one way hit in one set");

endmodule

// ==== source/valid_bit_store.sv ====
`timescale 1ns/10ps

module valid_bit_store (
	input  logic wclk,
	input  logic rst,
	input  logic [cache_geometry_pkg::index_w-1:0] rd_index_a,
	input  logic [cache_geometry_pkg::index_w-1:0] rd_index_b,
	output logic [cache_geometry_pkg::ways-1:0] valid_a,
	output logic [cache_geometry_pkg::ways-1:0] valid_b,
	input  logic upd_en,
	input  logic [cache_geometry_pkg::index_w-1:0] upd_index,
	input  logic [cache_geometry_pkg::ways-1:0] upd_valid
);
	import cache_geometry_pkg::*;

	// one flag per way for every set
	logic [ways-1:0] valid_mem [sets];

	// ==============================
	// flag update
	// ==============================

	// the updater has already worked out the new vector for the set
	always_ff @(posedge wclk) begin
		if (rst) begin
			for (int s = 0; s < sets; s++) begin
				valid_mem[s] <= '0;
			end
		end else if (upd_en) begin
			valid_mem[upd_index] <= upd_valid;
		end
	end

	// ==============================
	// flag read
	// ==============================

	// registered like the line store so tag and flag reach the matcher together
	always_ff @(posedge wclk) begin
		if (rst) begin
			valid_a <= '0;
			valid_b <= '0;
		end else begin
			valid_a <= valid_mem[rd_index_a];
			valid_b <= valid_mem[rd_index_b];
		end
	end

endmodule

// ==== source/cache_line_store.sv ====
`timescale 1ns/10ps

module cache_line_store (
	input  logic wclk,
	input  logic [cache_geometry_pkg::index_w-1:0] rd_index_a,
	input  logic [cache_geometry_pkg::index_w-1:0] rd_index_b,
	output logic [cache_geometry_pkg::ways*cache_geometry_pkg::entry_w-1:0] set_a,
	output logic [cache_geometry_pkg::ways*cache_geometry_pkg::entry_w-1:0] set_b,
	input  logic wr_en,
	input  logic [cache_geometry_pkg::index_w-1:0] wr_index,
	input  logic [cache_geometry_pkg::ways*cache_geometry_pkg::entry_w-1:0] wr_set
);
	import cache_geometry_pkg::*;

	// one word per set holds all ways side by side, way 0 in the low bits
	logic [ways*entry_w-1:0] mem [sets];

	// ==============================
	// write port
	// ==============================

	// the updater always sends back a complete set, so no per-way enables exist
	always_ff @(posedge wclk) begin
		if (wr_en) begin
			mem[wr_index] <= wr_set;
		end
	end

	// ==============================
	// read ports
	// ==============================

	// port a serves the read channel
	always_ff @(posedge wclk) begin
		set_a <= mem[rd_index_a];
	end

	// port b serves the lookup of the write side
	always_ff @(posedge wclk) begin
		set_b <= mem[rd_index_b];
	end

	// a write with an unknown index would corrupt a set that nobody can name
	a_wr_index_known: assert property (
		@(posedge wclk) wr_en |-> !$isunknown(wr_index)
	) else $error("line store written with unknown index");

endmodule

// ==== source/cache_geometry_pkg.sv ====
package cache_geometry_pkg;

	// ==============================
	// address split
	// ==============================

	localparam int addr_w = 32;

	// byte offset inside one line, one address per byte lane
	localparam int offset_w = 4;

	// set index, picks one of the sets
	localparam int index_w = 6;

	// whatever is left above the index is kept as the tag
	localparam int tag_w = addr_w - index_w - offset_w;

	// ==============================
	// cache shape
	// ==============================

	localparam int sets = 1 << index_w;
	localparam int ways = 4;
	localparam int way_w = $clog2(ways);

	// one way stores its tag above its line data
	localparam int entry_w = tag_w + cache_bus_pkg::data_w;

	// a request address, taken either as the raw word or split into fields
	typedef union packed {
		logic [addr_w-1:0] word;
		struct packed {
			logic [tag_w-1:0] tag;
			logic [index_w-1:0] index;
			logic [offset_w-1:0] offset;
		} fld;
	} cache_addr_t;

endpackage

// ==== source/cache_bus_pkg.sv ====
package cache_bus_pkg;

	// ==============================
	// data bus of the line port
	// ==============================

	// a whole cache line moves as one beat, so the bus is one line wide
	localparam int data_w = 128;

	// width of a single byte lane
	localparam int byte_w = 8;

	// one select bit for each byte lane of the line
	localparam int sel_w = data_w / byte_w;

endpackage
